// File: Bender.yml
package:
  name: bubl_main

sources:
  - include_dirs:
      - common
    files:
      - common/bubl_pkg.sv
      - design/bus_decode.sv
      - design/work_ram.sv
      - design/ctrl_regs.sv
      - design/sound_port.sv
      - design/read_mux.sv
      - design/bubl_main.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - verification/bubl_main_tb.sv

// File: all.f
+incdir+common
common/bubl_pkg.sv
design/bus_decode.sv
design/work_ram.sv
design/ctrl_regs.sv
design/sound_port.sv
design/read_mux.sv
design/bubl_main.sv
verification/bubl_main_tb.sv

// File: common/bubl_defines.svh
/* Bubble Bobble main-CPU bus glue
   Bus widths, memory map bounds and control register reset values */
`ifndef BUBL_DEFINES_SVH
`define BUBL_DEFINES_SVH

`define BUBL_AW          16
`define BUBL_DW          8
`define BUBL_ROM_AW      18
`define BUBL_WORK_AW     13
`define BUBL_WORK_DEPTH  6144     // 6 KB used out of the 8 KB window

// Bank arithmetic for the 8000-BFFF window
`define BUBL_BANK_OFS    4'd2
`define BUBL_BANK_XOR    3'd4
`define BUBL_UNMAPPED    8'hFF

// Memory map, inclusive bounds
`define BUBL_ROM_HI      16'hBFFF
`define BUBL_VRAM_LO     16'hC000
`define BUBL_VRAM_HI     16'hDFFF
`define BUBL_WORK_LO     16'hE000
`define BUBL_WORK_HI     16'hF7FF
`define BUBL_PAL_LO      16'hF800
`define BUBL_PAL_HI      16'hF9FF
`define BUBL_SND_LO      16'hFA00
`define BUBL_SND_HI      16'hFA7F
`define BUBL_MISC_LO     16'hFB40
`define BUBL_MISC_HI     16'hFB7F

`define BUBL_BANK_RST    3'd0
`define BUBL_BLACKN_RST  1'b0
`define BUBL_FLIP_RST    1'b0
`define BUBL_SUBRSTN_RST 1'b0
`define BUBL_MCURST_RST  1'b1

`endif

// File: common/bubl_pkg.sv
/* Bubble Bobble bus glue types
   Data byte, CPU and ROM addresses, memory regions */
`include "bubl_defines.svh"

package bubl_pkg;

    typedef logic [`BUBL_DW-1:0]     bubl_byte_t;
    typedef logic [`BUBL_AW-1:0]     bubl_addr_t;
    typedef logic [`BUBL_ROM_AW-1:0] bubl_rom_addr_t;

    // Decoded target of a memory cycle
    typedef enum logic [2:0] {
        region_none  = 3'd0,
        region_rom   = 3'd1,
        region_vram  = 3'd2,
        region_work  = 3'd3,
        region_pal   = 3'd4,
        region_sound = 3'd5,
        region_misc  = 3'd6   // writes only
    } bubl_region_e;

endpackage

// File: design/bubl_main.sv
/* Bubble Bobble main-CPU bus glue, top level
   Decode stage, work RAM, control and sound ports, read stage */
`timescale 1ns/100ps
`include "bubl_defines.svh"

module bubl_main import bubl_pkg::*; (
    input  logic           clk24,
    input  logic           rst,
    // Z80 bus
    input  logic           mreq_n,
    input  logic           rd_n,
    input  logic           wr_n,
    input  bubl_addr_t     addr,
    input  bubl_byte_t     cpu_dout,
    output bubl_byte_t     cpu_din,
    output logic           cpu_wait_n,
    // ROM
    output logic           main_rom_cs,
    output bubl_rom_addr_t main_rom_addr,
    input  logic           main_rom_ok,
    input  bubl_byte_t     main_rom_data,
    // Video
    output logic           vram_cs,
    output logic           pal_cs,
    output bubl_addr_t     cpu_addr,
    output bubl_byte_t     cpu_wdata,
    output logic           cpu_rnw,
    input  bubl_byte_t     vram_dout,
    input  bubl_byte_t     pal_dout,
    // Sound CPU
    input  bubl_byte_t     main_latch,
    output bubl_byte_t     snd_latch,
    output logic           snd_stb,
    input  logic           snd_flag,
    input  logic           main_stb,
    output logic           main_flag,
    output logic           snd_rstn,
    // Board control
    output logic           black_n,
    output logic           flip,
    output logic           sub_rst_n,
    output logic           mcu_rst
);

bubl_region_e region;
logic         wr_stb;
logic         rd_stb;
logic [2:0]   bank;
logic         work_we;
bubl_byte_t   work_rdata;
bubl_byte_t   snd_rdata;

assign work_we = wr_stb && region == region_work;

bus_decode u_decode (
    .clk24         ( clk24         ),
    .rst           ( rst           ),
    .mreq_n        ( mreq_n        ),
    .rd_n          ( rd_n          ),
    .wr_n          ( wr_n          ),
    .addr          ( addr          ),
    .cpu_dout      ( cpu_dout      ),
    .bank          ( bank          ),
    .main_rom_ok   ( main_rom_ok   ),
    .region        ( region        ),
    .cpu_addr      ( cpu_addr      ),
    .cpu_wdata     ( cpu_wdata     ),
    .wr_stb        ( wr_stb        ),
    .rd_stb        ( rd_stb        ),
    .cpu_rnw       ( cpu_rnw       ),
    .main_rom_cs   ( main_rom_cs   ),
    .main_rom_addr ( main_rom_addr ),
    .vram_cs       ( vram_cs       ),
    .pal_cs        ( pal_cs        ),
    .cpu_wait_n    ( cpu_wait_n    )
);

work_ram u_work (
    .clk24 ( clk24                          ),
    .we    ( work_we                        ),
    .addr  ( cpu_addr[`BUBL_WORK_AW-1:0]    ),
    .wdata ( cpu_wdata                      ),
    .rdata ( work_rdata                     )
);

ctrl_regs u_ctrl (
    .clk24     ( clk24     ),
    .rst       ( rst       ),
    .region    ( region    ),
    .wr_stb    ( wr_stb    ),
    .cpu_wdata ( cpu_wdata ),
    .bank      ( bank      ),
    .black_n   ( black_n   ),
    .flip      ( flip      ),
    .sub_rst_n ( sub_rst_n ),
    .mcu_rst   ( mcu_rst   )
);

sound_port u_sound (
    .clk24      ( clk24      ),
    .rst        ( rst        ),
    .region     ( region     ),
    .wr_stb     ( wr_stb     ),
    .rd_stb     ( rd_stb     ),
    .cpu_addr   ( cpu_addr   ),
    .cpu_wdata  ( cpu_wdata  ),
    .main_latch ( main_latch ),
    .snd_flag   ( snd_flag   ),
    .main_stb   ( main_stb   ),
    .snd_latch  ( snd_latch  ),
    .snd_stb    ( snd_stb    ),
    .snd_rstn   ( snd_rstn   ),
    .main_flag  ( main_flag  ),
    .snd_rdata  ( snd_rdata  )
);

read_mux u_rdmux (
    .clk24         ( clk24         ),
    .rst           ( rst           ),
    .region        ( region        ),
    .rd_stb        ( rd_stb        ),
    .main_rom_data ( main_rom_data ),
    .vram_dout     ( vram_dout     ),
    .pal_dout      ( pal_dout      ),
    .work_rdata    ( work_rdata    ),
    .snd_rdata     ( snd_rdata     ),
    .cpu_din       ( cpu_din       )
);

endmodule

// File: design/bus_decode.sv
/* Stage 1 of the main-CPU bus glue
   Registers the Z80 request, decodes the region and banks the ROM address */
`timescale 1ns/100ps
`include "bubl_defines.svh"

module bus_decode import bubl_pkg::*; (
    input  logic           clk24,
    input  logic           rst,
    input  logic           mreq_n,
    input  logic           rd_n,
    input  logic           wr_n,
    input  bubl_addr_t     addr,
    input  bubl_byte_t     cpu_dout,
    input  logic [2:0]     bank,
    input  logic           main_rom_ok,
    output bubl_region_e   region,
    output bubl_addr_t     cpu_addr,
    output bubl_byte_t     cpu_wdata,
    output logic           wr_stb,
    output logic           rd_stb,
    output logic           cpu_rnw,
    output logic           main_rom_cs,
    output bubl_rom_addr_t main_rom_addr,
    output logic           vram_cs,
    output logic           pal_cs,
    output logic           cpu_wait_n
);

bubl_region_e   region_d;
bubl_rom_addr_t rom_addr_d;

// Address decoder
always_comb begin
    region_d = region_none;
    if (!mreq_n) begin
        if (addr <= `BUBL_ROM_HI)
            region_d = region_rom;
        else if (addr >= `BUBL_VRAM_LO && addr <= `BUBL_VRAM_HI)
            region_d = region_vram;
        else if (addr >= `BUBL_WORK_LO && addr <= `BUBL_WORK_HI)
            region_d = region_work;
        else if (addr >= `BUBL_PAL_LO && addr <= `BUBL_PAL_HI)
            region_d = region_pal;
        else if (addr >= `BUBL_SND_LO && addr <= `BUBL_SND_HI)
            region_d = region_sound;
        else if (addr >= `BUBL_MISC_LO && addr <= `BUBL_MISC_HI)
            region_d = region_misc;
    end
end

// 8000-BFFF goes through the bank register, lower half is flat
always_comb begin
    if (addr[15])
        rom_addr_d = {({1'b0, bank} + `BUBL_BANK_OFS), addr[13:0]};
    else
        rom_addr_d = {2'b00, addr};
end

always_ff @(posedge clk24, posedge rst) begin
    if (rst) begin
        region      <= region_none;
        wr_stb      <= 1'b0;
        rd_stb      <= 1'b0;
        cpu_rnw     <= 1'b1;
        main_rom_cs <= 1'b0;
        vram_cs     <= 1'b0;
        pal_cs      <= 1'b0;
    end else begin
        region      <= region_d;
        wr_stb      <= !mreq_n && !wr_n;
        rd_stb      <= !mreq_n && !rd_n;
        cpu_rnw     <= mreq_n || wr_n;   // Low only during a write
        main_rom_cs <= region_d == region_rom;
        vram_cs     <= region_d == region_vram;
        pal_cs      <= region_d == region_pal;
    end
end

// Request payload
always_ff @(posedge clk24) begin
    cpu_addr      <= addr;
    cpu_wdata     <= cpu_dout;
    main_rom_addr <= rom_addr_d;
end

// Hold the CPU until SDRAM data is there
assign cpu_wait_n = !(main_rom_cs && !main_rom_ok);

endmodule

// File: design/ctrl_regs.sv
/* Miscellaneous control register at FB40-FB7F
   ROM bank, screen blanking, flip and reset lines of the sub CPU and MCU */
`timescale 1ns/100ps
`include "bubl_defines.svh"

module ctrl_regs import bubl_pkg::*; (
    input  logic         clk24,
    input  logic         rst,
    input  bubl_region_e region,
    input  logic         wr_stb,
    input  bubl_byte_t   cpu_wdata,
    output logic [2:0]   bank,
    output logic         black_n,
    output logic         flip,
    output logic         sub_rst_n,
    output logic         mcu_rst
);

logic misc_we;

assign misc_we = wr_stb && region == region_misc;

////////////////////////////////////////////////////////////
// Register bit map
//   7 flip, 6 black_n, 5 MCU reset (low active on PCB)
//   4 sub CPU run, 2..0 ROM bank
////////////////////////////////////////////////////////////

always_ff @(posedge clk24, posedge rst) begin
    if (rst) begin
        bank      <= `BUBL_BANK_RST;
        black_n   <= `BUBL_BLACKN_RST;
        flip      <= `BUBL_FLIP_RST;
        sub_rst_n <= `BUBL_SUBRSTN_RST;
        mcu_rst   <= `BUBL_MCURST_RST;
    end else if (misc_we) begin
        bank      <= cpu_wdata[2:0] ^ `BUBL_BANK_XOR;  // Top bank bit is inverted
        black_n   <= cpu_wdata[6];
        flip      <= cpu_wdata[7];
        sub_rst_n <= cpu_wdata[4];
        mcu_rst   <= ~cpu_wdata[5];
    end
end

endmodule

// File: design/read_mux.sv
/* Stage 2 of the main-CPU bus glue
   Captures every read source and registers the byte returned to the Z80 */
`timescale 1ns/100ps
`include "bubl_defines.svh"

module read_mux import bubl_pkg::*; (
    input  logic         clk24,
    input  logic         rst,
    input  bubl_region_e region,
    input  logic         rd_stb,
    input  bubl_byte_t   main_rom_data,
    input  bubl_byte_t   vram_dout,
    input  bubl_byte_t   pal_dout,
    input  bubl_byte_t   work_rdata,
    input  bubl_byte_t   snd_rdata,
    output bubl_byte_t   cpu_din
);

bubl_region_e rd_region;
bubl_byte_t   rom_q;
bubl_byte_t   vram_q;
bubl_byte_t   pal_q;
bubl_byte_t   snd_q;

// Only read cycles pick a source
always_ff @(posedge clk24, posedge rst) begin
    if (rst)
        rd_region <= region_none;
    else
        rd_region <= rd_stb ? region : region_none;
end

// External data as seen during the stage-1 cycle
always_ff @(posedge clk24) begin
    rom_q  <= main_rom_data;
    vram_q <= vram_dout;
    pal_q  <= pal_dout;
    snd_q  <= snd_rdata;
end

always_ff @(posedge clk24) begin
    case (rd_region)
        region_rom:   cpu_din <= rom_q;
        region_vram:  cpu_din <= vram_q;
        region_work:  cpu_din <= work_rdata;   // Already registered by the RAM
        region_pal:   cpu_din <= pal_q;
        region_sound: cpu_din <= snd_q;
        default:      cpu_din <= `BUBL_UNMAPPED;  // Unmapped and misc
    endcase
end

endmodule

// File: design/sound_port.sv
/* Main CPU side of the sound CPU link
   Command latch and strobe, sound reset and the reply handshake */
`timescale 1ns/100ps
`include "bubl_defines.svh"

module sound_port import bubl_pkg::*; (
    input  logic         clk24,
    input  logic         rst,
    input  bubl_region_e region,
    input  logic         wr_stb,
    input  logic         rd_stb,
    input  bubl_addr_t   cpu_addr,
    input  bubl_byte_t   cpu_wdata,
    input  bubl_byte_t   main_latch,
    input  logic         snd_flag,
    input  logic         main_stb,
    output bubl_byte_t   snd_latch,
    output logic         snd_stb,
    output logic         snd_rstn,
    output logic         main_flag,
    output bubl_byte_t   snd_rdata
);

logic snd_we;
logic snd_rd;
logic main_stb_l;
logic pending;

assign snd_we = wr_stb && region == region_sound;
assign snd_rd = rd_stb && region == region_sound;

////////////////////////////////////////////////////////////
// Writes towards the sound CPU
////////////////////////////////////////////////////////////

always_ff @(posedge clk24, posedge rst) begin
    if (rst) begin
        snd_latch <= '0;
        snd_stb   <= 1'b0;
        snd_rstn  <= 1'b1;     // Sound CPU runs after reset
    end else begin
        snd_stb <= snd_we && cpu_addr[1:0] == 2'b00;  // One cycle only
        if (snd_we) begin
            case (cpu_addr[1:0])
                2'b00:   snd_latch <= cpu_wdata;
                2'b11:   snd_rstn  <= ~cpu_wdata[0];
                default: ;
            endcase
        end
    end
end

////////////////////////////////////////////////////////////
// Reply handshake
////////////////////////////////////////////////////////////

// Set by a new reply, cleared once the main CPU reads the port
always_ff @(posedge clk24, posedge rst) begin
    if (rst) begin
        main_stb_l <= 1'b0;
        pending    <= 1'b0;
    end else begin
        main_stb_l <= main_stb;
        if (main_stb && !main_stb_l)
            pending <= 1'b1;   // A fresh reply is never lost
        else if (snd_rd)
            pending <= 1'b0;
    end
end

assign main_flag = pending;

// Odd address reads the status byte
assign snd_rdata = cpu_addr[0] ? {6'h3f, main_flag, snd_flag} : main_latch;

endmodule

// File: design/work_ram.sv
/* Main CPU work RAM, 6 KB synchronous single port */
`timescale 1ns/100ps
`include "bubl_defines.svh"

module work_ram import bubl_pkg::*; (
    input  logic                     clk24,
    input  logic                     we,
    input  logic [`BUBL_WORK_AW-1:0] addr,
    input  bubl_byte_t               wdata,
    output bubl_byte_t               rdata
);

bubl_byte_t mem [0:`BUBL_WORK_DEPTH-1];

// Old contents come out on a write cycle
always_ff @(posedge clk24) begin
    if (we)
        mem[addr] <= wdata;
    rdata <= mem[addr];
end

endmodule

// File: verification/bubl_main_tb.sv
/* Testbench for the Bubble Bobble main-CPU bus glue
   Reference model, pipelined Z80 accesses, read comparison and watchdog */
`timescale 1ns/100ps
`include "bubl_defines.svh"

module bubl_main_tb import bubl_pkg::*; ();

localparam int RST_CYCLES = 5;
localparam int N_WORK     = 24;
localparam int N_BANK     = 4;
localparam int N_VIDEO    = 12;

logic           clk24 = 1'b0;
logic           rst;
logic           mreq_n;
logic           rd_n;
logic           wr_n;
bubl_addr_t     addr;
bubl_byte_t     cpu_dout;
bubl_byte_t     cpu_din;
logic           cpu_wait_n;
logic           main_rom_cs;
bubl_rom_addr_t main_rom_addr;
logic           main_rom_ok;
bubl_byte_t     main_rom_data;
logic           vram_cs;
logic           pal_cs;
bubl_addr_t     cpu_addr;
bubl_byte_t     cpu_wdata;
logic           cpu_rnw;
bubl_byte_t     vram_dout;
bubl_byte_t     pal_dout;
bubl_byte_t     main_latch;
bubl_byte_t     snd_latch;
logic           snd_stb;
logic           snd_flag;
logic           main_stb;
logic           main_flag;
logic           snd_rstn;
logic           black_n;
logic           flip;
logic           sub_rst_n;
logic           mcu_rst;

// Reference model state
bubl_byte_t     work_mdl [0:8191];
logic [2:0]     bank_mdl;
logic           flag_mdl;         // Reply pending towards the main CPU
logic [31:0]    rng;
int             cyc = 0;
int             n_issued = 0;
int             din_due [$];
bubl_byte_t     din_exp [$];
bubl_addr_t     din_adr [$];
bubl_addr_t     work_used [$];

bubl_main dut (.*);

always #2 clk24 = ~clk24;

always @(posedge clk24) cyc <= cyc + 1;

// External memories as fixed functions of the address
assign main_rom_data = rom_byte(main_rom_addr);
assign vram_dout     = vram_byte(cpu_addr);
assign pal_dout      = pal_byte(cpu_addr);

function automatic bubl_byte_t rom_byte(input bubl_rom_addr_t a);
    return a[7:0] ^ a[15:8] ^ {6'd0, a[17:16]};
endfunction

function automatic bubl_byte_t vram_byte(input bubl_addr_t a);
    return a[7:0] ^ a[12:5];
endfunction

function automatic bubl_byte_t pal_byte(input bubl_addr_t a);
    return ~a[7:0] + a[8];
endfunction

function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

////////////////////////////////////////////////////////////
// Reference model
////////////////////////////////////////////////////////////

function automatic bubl_region_e region_of(input bubl_addr_t a);
    if (a <= 16'hBFFF)
        return region_rom;
    else if (a <= 16'hDFFF)
        return region_vram;
    else if (a <= 16'hF7FF)
        return region_work;
    else if (a <= 16'hF9FF)
        return region_pal;
    else if (a <= 16'hFA7F)
        return region_sound;
    else if (a >= 16'hFB40 && a <= 16'hFB7F)
        return region_misc;
    return region_none;
endfunction

// Upper half of the ROM space goes through bank + 2
function automatic bubl_rom_addr_t banked_rom_addr(input bubl_addr_t a);
    logic [3:0] hi;
    hi = bank_mdl + 4'd2;
    if (!a[15])
        return {2'b00, a};
    return {hi, a[13:0]};
endfunction

function automatic bubl_byte_t expected_read(input bubl_addr_t a);
    case (region_of(a))
        region_rom:   return rom_byte(banked_rom_addr(a));
        region_vram:  return vram_byte(a);
        region_work:  return work_mdl[a[12:0]];
        region_pal:   return pal_byte(a);
        region_sound: return a[0] ? {6'h3f, flag_mdl, snd_flag} : main_latch;
        default:      return 8'hFF;
    endcase
endfunction

task automatic model_write(input bubl_addr_t a, input bubl_byte_t d);
    case (region_of(a))
        region_work: work_mdl[a[12:0]] = d;
        region_misc: bank_mdl = d[2:0] ^ 3'd4;
        default:     ;
    endcase
endtask

task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1, "Run stopped at the first error");
endtask

task automatic expect_val(input string what, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
    else stop_run($sformatf("Mismatch at %0t: %s is %0h, expected %0h", $time, what, got, exp));
endtask

// One bus cycle that returns 1 ns after its sampling edge
task automatic access(input logic wr, input bubl_addr_t a, input bubl_byte_t d);
    bubl_region_e r;
    r        = region_of(a);
    mreq_n   = 1'b0;
    rd_n     = wr;
    wr_n     = !wr;
    addr     = a;
    cpu_dout = d;
    if (wr) begin
        model_write(a, d);
    end else begin
        din_due.push_back(cyc + 3);   // Data due two edges after the sampling edge
        din_exp.push_back(expected_read(a));
        din_adr.push_back(a);
        if (r == region_sound)
            flag_mdl = 1'b0;
    end
    n_issued++;
    @(posedge clk24);
    #1;
    expect_val("cpu_addr", cpu_addr, a);
    expect_val("selects {rom, vram, pal, rnw}", {main_rom_cs, vram_cs, pal_cs, cpu_rnw},
               {r == region_rom, r == region_vram, r == region_pal, !wr});
    if (wr)
        expect_val("cpu_wdata", cpu_wdata, d);
    if (r == region_rom)
        expect_val("main_rom_addr", main_rom_addr, banked_rom_addr(a));
endtask

task automatic idle(input int n);
    repeat (n) begin
        mreq_n = 1'b1;
        rd_n   = 1'b1;
        wr_n   = 1'b1;
        @(posedge clk24);
        #1;
    end
endtask

// Z80 keeps its ROM read on the bus while WAIT is low
task automatic stalled_read(input bubl_addr_t a, input int hold);
    int stalls;
    stalls = 0;
    main_rom_ok = 1'b0;
    access(1'b0, a, 8'h00);
    while (!cpu_wait_n) begin
        stalls++;
        assert (stalls <= hold) else stop_run("cpu_wait_n stayed low after main_rom_ok rose");
        if (stalls == hold)
            main_rom_ok = 1'b1;   // ROM data ready
        access(1'b0, a, 8'h00);
    end
    assert (stalls == hold) else stop_run("cpu_wait_n did not stall the ROM read");
endtask

////////////////////////////////////////////////////////////
// Compare and watchdog
////////////////////////////////////////////////////////////

always @(negedge clk24) begin : compare
    bubl_byte_t exp_byte;
    bubl_addr_t exp_addr;
    if (din_due.size() > 0 && din_due[0] == cyc) begin
        din_due.delete(0);
        exp_byte = din_exp.pop_front();
        exp_addr = din_adr.pop_front();
        expect_val($sformatf("cpu_din for read of %h", exp_addr), cpu_din, exp_byte);
    end
end

always @(posedge clk24) begin : watchdog
    if (cyc > RST_CYCLES + 20 * (n_issued + 1))
        stop_run("Watchdog expired, no bus access made progress");
end

initial begin : stimulus
    bubl_addr_t a;
    bubl_byte_t d;
    rst         = 1'b1;
    mreq_n      = 1'b1;
    rd_n        = 1'b1;
    wr_n        = 1'b1;
    addr        = '0;
    cpu_dout    = '0;
    main_rom_ok = 1'b1;
    main_latch  = 8'h6C;
    snd_flag    = 1'b1;
    main_stb    = 1'b0;
    bank_mdl    = 3'd0;
    flag_mdl    = 1'b0;
    rng         = 32'd44;
    repeat (RST_CYCLES) @(posedge clk24);
    #1;
    rst = 1'b0;
    expect_val("reset state", {black_n, flip, sub_rst_n, mcu_rst, snd_stb, snd_rstn, main_flag,
               vram_cs, pal_cs, main_rom_cs, cpu_rnw, cpu_wait_n, snd_latch},
               {12'b0001_0100_0011, 8'h00});

    // Back-to-back work RAM writes then reads
    for (int i = 0; i < N_WORK; i++) begin
        rng = xorshift(rng);
        a   = 16'hE000 + rng[15:0] % 16'd6144;
        work_used.push_back(a);
        access(1'b1, a, rng[23:16]);
    end
    foreach (work_used[i])
        access(1'b0, work_used[i], 8'h00);

    // Misc register and ROM banking
    for (int i = 0; i < N_BANK; i++) begin
        rng = xorshift(rng);
        d   = rng[7:0];
        access(1'b1, 16'hFB40 | {10'd0, rng[13:8]}, d);
        idle(1);   // New bank reaches the decoder
        expect_val("{black_n, flip, sub_rst_n, mcu_rst}", {black_n, flip, sub_rst_n, mcu_rst},
                   {d[6], d[7], d[4], !d[5]});
        access(1'b0, 16'h4000, 8'h00);
        rng = xorshift(rng);
        access(1'b0, 16'h8000 | {2'b00, rng[13:0]}, 8'h00);
        access(1'b0, 16'h8000 | {2'b00, rng[29:16]}, 8'h00);
        stalled_read(16'h8000 | {2'b00, rng[27:14]}, 2 + i % 3);
    end

    // Sound latch, strobe and reset
    rng = xorshift(rng);
    d   = rng[7:0];
    access(1'b1, 16'hFA00 | {9'd0, rng[14:10], 2'b00}, d);
    idle(1);
    expect_val("snd_latch", snd_latch, d);
    expect_val("snd_stb", snd_stb, 1'b1);
    idle(1);
    expect_val("snd_stb", snd_stb, 1'b0);
    access(1'b1, 16'hFA03, 8'h01);
    idle(1);
    expect_val("snd_rstn", snd_rstn, 1'b0);
    access(1'b1, 16'hFA07, 8'hFE);
    idle(1);
    expect_val("snd_rstn", snd_rstn, 1'b1);

    // Reply handshake
    access(1'b0, 16'hFA01, 8'h00);
    idle(1);
    main_stb = 1'b1;
    snd_flag = 1'b0;   // Sound side now busy
    flag_mdl = 1'b1;
    idle(1);
    expect_val("main_flag", main_flag, 1'b1);
    access(1'b0, 16'hFA05, 8'h00);
    idle(1);
    expect_val("main_flag", main_flag, 1'b0);   // Held main_stb is no new edge
    main_stb = 1'b0;
    access(1'b0, 16'hFA00, 8'h00);
    access(1'b0, 16'hFA7E, 8'h00);

    // Video, palette and unmapped space
    for (int i = 0; i < N_VIDEO; i++) begin
        rng = xorshift(rng);
        access(1'b0, 16'hC000 | {3'd0, rng[12:0]}, 8'h00);
        access(1'b0, 16'hF800 | {7'd0, rng[24:16]}, 8'h00);
        access(1'b0, 16'hFA80 + rng[31:16] % 16'h0580, 8'h00);
        access(1'b1, 16'hC000 | {3'd0, rng[28:16]}, rng[7:0]);
    end

    idle(4);
    if (din_due.size() == 0) begin
        $display("Regression passed");
        $finish;
    end else begin
        stop_run("Reads were still waiting for their data at the end of the run");
    end
end

endmodule
